// ==== hw/jpegls_pack_pkg.sv ====
package jpegls_pack_pkg;

	// longest code word the entropy coder can hand over in one go
	localparam int CODE_W = 32;

	// a length field has to hold 0 up to CODE_W inclusive
	localparam int LEN_W = 6;

	// bit accumulator, MSB aligned, wide enough for one full code word on top of
	// whatever is still pending from earlier words
	localparam int ACC_W = 64;

	// pending bit count runs from 0 up to ACC_W inclusive
	localparam int CNT_W = $clog2(ACC_W + 1);

	// input FIFO depth, which is also the number of credits upstream starts with
	localparam int IN_DEPTH = 4;

	// output byte FIFO depth and the packer's credit count toward it
	localparam int OUT_DEPTH   = 4;
	localparam int PACK_CRED_W = $clog2(OUT_DEPTH + 1);

	// credits the sender holds toward the consumer after reset
	localparam int OUT_CREDITS = 4;
	localparam int SEND_CRED_W = $clog2(OUT_CREDITS + 1);

	// a byte of all ones looks like a marker prefix in the JPEG-LS stream
	localparam logic [7:0] MARKER_BYTE = 8'hFF;

	// one code word from the coder, bits right aligned in the low len positions
	// flush ends the scan once these bits have been packed
	typedef struct packed {
		logic [CODE_W-1:0] bits;
		logic [LEN_W-1:0]  len;
		logic              flush;
	} code_word_t;

	// one packed byte on its way out, last marks the final byte of a scan
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} out_byte_t;

endpackage

// ==== hw/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	output logic     head_valid,
	output payload_t head_data,
	input  logic     pop,
	output logic     credit
);

	// pointer and fill widths follow the depth of this instance
	localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int FILL_W = $clog2(DEPTH + 1);

	payload_t          mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [FILL_W-1:0] fill;
	logic              do_push;
	logic              do_pop;

	// the far side spends credits, so a push into a full buffer only happens
	// when the credit protocol is broken; such a push is dropped
	assign do_push = push && (fill != FILL_W'(DEPTH));

	// popping an empty buffer does nothing and returns no credit
	assign do_pop = pop && head_valid;

	// the head is simply the slot under the read pointer
	assign head_valid = (fill != '0);
	assign head_data  = mem[rd_ptr];

	// storage array, written at the tail
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
			credit <= 1'b0;
		end else begin
			// tail pointer wraps at the last slot, DEPTH need not be a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop in the same cycle leave the fill level alone
			fill <= fill + FILL_W'(do_push) - FILL_W'(do_pop);
			// every released slot goes back to the producer as a one cycle pulse
			credit <= do_pop;
		end
	end

endmodule

// ==== hw/stuffing_packer.sv ====
`timescale 1ns/1ps

module stuffing_packer
	import jpegls_pack_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       code_valid,
	input  code_word_t code,
	output logic       code_pop,
	output logic       byte_push,
	output out_byte_t  byte_data,
	input  logic       byte_credit
);

	// pending bits sit at the top of acc, everything below them is zero
	logic [ACC_W-1:0]       acc;
	logic [ACC_W-1:0]       acc_next;
	logic [ACC_W-1:0]       acc_sh;
	logic [ACC_W-1:0]       app_word;
	logic [CNT_W-1:0]       cnt;
	logic [CNT_W-1:0]       cnt_next;
	logic [CNT_W-1:0]       cnt_cut;
	logic [CNT_W-1:0]       shamt;
	logic [CODE_W-1:0]      code_mask;
	logic [3:0]             take;
	logic [7:0]             cut_data;
	logic [PACK_CRED_W-1:0] cred;
	logic                   prev_ff;
	logic                   flushing;
	logic                   has_credit;
	logic                   normal_cut;
	logic                   flush_cut;
	logic                   final_cut;
	logic                   zero_emit;
	logic                   end_scan;

	always_comb begin
		// after a marker byte only seven data bits fit, the MSB is stuffed with zero
		take     = prev_ff ? 4'd7 : 4'd8;
		cut_data = prev_ff ? {1'b0, acc[ACC_W-1 -: 7]} : acc[ACC_W-1 -: 8];

		has_credit = (cred != '0);

		// outside a flush one full byte plus at least one bit must be pending
		// so the final byte of a scan is still around when the flush comes in
		// and can carry the last flag
		normal_cut = !flushing && (cnt > CNT_W'(take));

		// during a flush everything pending drains, the tail is zero padded
		flush_cut = flushing && (cnt != '0);
		final_cut = flush_cut && (cnt <= CNT_W'(take));

		// an empty accumulator with the marker flag still set during a flush
		// means the padded final byte came out as 0xFF
		zero_emit = flushing && (cnt == '0) && prev_ff;

		byte_push = has_credit && (normal_cut || flush_cut || zero_emit);

		byte_data.data = zero_emit ? 8'h00 : cut_data;
		// a padded 0xFF cannot end the scan, the extra zero byte does instead
		byte_data.last = zero_emit || (final_cut && (cut_data != MARKER_BYTE));

		// a flush on an empty scan finishes without sending anything
		end_scan = flushing &&
			((byte_push && byte_data.last) || ((cnt == '0) && !prev_ff));

		// room for a full code word is needed before the next one is taken
		// and nothing new comes in until the current scan is closed
		code_pop = code_valid && !flushing && (cnt <= CNT_W'(ACC_W - CODE_W));

		// drop the bits of the byte being cut, zeros shift in from the bottom
		acc_sh = byte_push ? (acc << take) : acc;
		if (!byte_push) begin
			cnt_cut = cnt;
		end else if (cnt > CNT_W'(take)) begin
			cnt_cut = cnt - CNT_W'(take);
		end else begin
			cnt_cut = '0;
		end

		// bits above len are not guaranteed to be zero, so mask them off
		// (a shift by the full width clears the word, giving an all ones mask)
		code_mask = ~({CODE_W{1'b1}} << code.len);

		// place the new word right under the bits that stay pending
		shamt    = CNT_W'(ACC_W) - cnt_cut - CNT_W'(code.len);
		app_word = {{(ACC_W - CODE_W){1'b0}}, code.bits & code_mask} << shamt;

		acc_next = code_pop ? (acc_sh | app_word) : acc_sh;
		cnt_next = code_pop ? (cnt_cut + CNT_W'(code.len)) : cnt_cut;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc      <= '0;
			cnt      <= '0;
			prev_ff  <= 1'b0;
			flushing <= 1'b0;
			cred     <= PACK_CRED_W'(OUT_DEPTH);
		end else begin
			acc <= acc_next;
			cnt <= cnt_next;

			// one credit per pushed byte, one back per byte the sender pops
			cred <= cred - PACK_CRED_W'(byte_push) + PACK_CRED_W'(byte_credit);

			// the stuffing rule never carries over into the next scan
			if (end_scan) begin
				prev_ff <= 1'b0;
			end else if (byte_push) begin
				prev_ff <= (byte_data.data == MARKER_BYTE);
			end

			// pop and scan end never meet since pops are held off during a flush
			if (end_scan) begin
				flushing <= 1'b0;
			end else if (code_pop && code.flush) begin
				flushing <= 1'b1;
			end
		end
	end

endmodule

// ==== hw/byte_sender.sv ====
`timescale 1ns/1ps

module byte_sender
	import jpegls_pack_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       fifo_valid,
	input  out_byte_t  fifo_data,
	output logic       fifo_pop,
	output logic       out_valid,
	output logic [7:0] out_data,
	output logic       out_last,
	input  logic       out_credit
);

	// free slots known to be available at the consumer
	logic [SEND_CRED_W-1:0] credits;

	// a byte leaves only if one is waiting and the consumer has room for it
	assign fifo_pop = fifo_valid && (credits != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits   <= SEND_CRED_W'(OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			// a pop spends a credit, each out_credit pulse hands one back
			credits <= credits - SEND_CRED_W'(fifo_pop) + SEND_CRED_W'(out_credit);
			// valid stays up for exactly the one cycle after the pop
			out_valid <= fifo_pop;
		end
	end

	// byte and last flag are only meaningful while out_valid is high
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			out_data <= fifo_data.data;
			out_last <= fifo_data.last;
		end
	end

endmodule

// ==== hw/jpegls_bit_packer.sv ====
`timescale 1ns/1ps

module jpegls_bit_packer
	import jpegls_pack_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  code_word_t in_code,
	output logic       in_credit,
	output logic       out_valid,
	output logic [7:0] out_data,
	output logic       out_last,
	input  logic       out_credit
);

	// code word path between the input FIFO and the packer
	logic       code_valid;
	code_word_t code;
	logic       code_pop;

	// byte path from the packer through the output FIFO to the sender
	logic      byte_push;
	out_byte_t byte_data;
	logic      byte_credit;
	logic      fifo_valid;
	out_byte_t fifo_data;
	logic      fifo_pop;

	// upstream spends its IN_DEPTH credits into this buffer
	credit_fifo #(
		.payload_t (code_word_t),
		.DEPTH     (IN_DEPTH)
	) u_in_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (in_valid),
		.push_data  (in_code),
		.head_valid (code_valid),
		.head_data  (code),
		.pop        (code_pop),
		.credit     (in_credit)
	);

	stuffing_packer u_packer (
		.clk         (clk),
		.rst_n       (rst_n),
		.code_valid  (code_valid),
		.code        (code),
		.code_pop    (code_pop),
		.byte_push   (byte_push),
		.byte_data   (byte_data),
		.byte_credit (byte_credit)
	);

	// its credit pulses flow back to the packer, not to the outside
	credit_fifo #(
		.payload_t (out_byte_t),
		.DEPTH     (OUT_DEPTH)
	) u_out_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (byte_push),
		.push_data  (byte_data),
		.head_valid (fifo_valid),
		.head_data  (fifo_data),
		.pop        (fifo_pop),
		.credit     (byte_credit)
	);

	byte_sender u_sender (
		.clk        (clk),
		.rst_n      (rst_n),
		.fifo_valid (fifo_valid),
		.fifo_data  (fifo_data),
		.fifo_pop   (fifo_pop),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_last   (out_last),
		.out_credit (out_credit)
	);

endmodule

// ==== dv/jpegls_packer_properties.sv ====
`timescale 1ns/1ps

module jpegls_packer_properties
	import jpegls_pack_pkg::*;
(
	input logic                   clk,
	input logic                   rst_n,
	input logic                   out_valid,
	input logic                   out_credit,
	input logic [SEND_CRED_W-1:0] credits
);

	// free slots at the consumer as seen from the ports alone
	// each byte shown on out_valid takes a slot and each out_credit pulse frees one
	int room;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			room <= OUT_CREDITS;
		end else begin
			room <= room - int'(out_valid) + int'(out_credit);
		end
	end

	// a byte may only appear while the consumer still has a free slot for it
	credit_before_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> (room > 0)
	) else $error("out_valid asserted while the consumer had no free slot");

	// the consumer never hands back more credits than it started with
	credits_bounded: assert property (
		@(posedge clk) disable iff (!rst_n)
		credits <= SEND_CRED_W'(OUT_CREDITS)
	) else $error("sender credit count above its reset value");

	// no byte may leak out while the block is held in reset
	quiet_in_reset: assert property (
		@(posedge clk)
		!rst_n |-> !out_valid
	) else $error("out_valid high during reset");

endmodule

bind byte_sender jpegls_packer_properties u_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_credit (out_credit),
	.credits    (credits)
);

// ==== dv/tb_jpegls_bit_packer.sv ====
`timescale 1ns/1ps

module tb_jpegls_bit_packer
	import jpegls_pack_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int SCAN_TIMEOUT = 1000;

	// the watchdog budget is derived from the number of code words in each test
	localparam int T1_WORDS        = 7;
	localparam int T2_WORDS        = 5;
	localparam int T3_WORDS        = 3;
	localparam int T4_WORDS        = 14;
	localparam int T5_WORDS        = 20;
	localparam int TOTAL_WORDS     = T1_WORDS + T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 200;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	code_word_t in_code;
	logic       in_credit;
	logic       out_valid;
	logic [7:0] out_data;
	logic       out_last;
	logic       out_credit;

	logic [31:0] lfsr_state;
	int          in_cred;
	int          owed;
	int          credit_gap;
	int          gap_cnt;
	logic        credit_on;

	// the reference model keeps a plain bit stream per scan
	bit          model_bits[$];
	logic        model_prev_ff;
	out_byte_t   exp_q[$];
	out_byte_t   got_q[$];
	int          scans_sent;
	int          scans_done;

	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;

	jpegls_bit_packer DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_code    (in_code),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_last   (out_last),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// every byte that leaves is recorded and owes the DUT one credit
	always @(posedge clk) begin
		if (out_valid) begin
			got_q.push_back({out_data, out_last});
			owed++;
			if (out_last) begin
				scans_done++;
			end
		end
	end

	// the producer side gets a slot back for each in_credit pulse
	always @(posedge clk) begin
		if (in_credit) begin
			in_cred++;
		end
	end

	// the consumer returns one credit per pulse and waits credit_gap cycles between pulses
	initial begin
		forever begin
			@(posedge clk);
			#1;
			out_credit = 1'b0;
			if (gap_cnt != 0) begin
				gap_cnt--;
			end else if (credit_on && owed != 0) begin
				out_credit = 1'b1;
				owed--;
				gap_cnt = credit_gap;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run never completed", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	// feedback from taps 32 22 2 and 1 with one step for every bit handed out
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic code_word_t make_code(input logic [31:0] bits, input int len,
			input logic flush);
		code_word_t w;
		w.bits  = bits;
		w.len   = LEN_W'(len);
		w.flush = flush;
		return w;
	endfunction

	// takes 8 bits or a forced zero and 7 bits after a marker and fills a short tail with zeros
	function automatic logic [7:0] cut_model_byte();
		int         take;
		logic [7:0] b;
		take = model_prev_ff ? 7 : 8;
		b    = 8'h00;
		for (int i = take - 1; i >= 0; i--) begin
			if (model_bits.size() != 0) begin
				b[i] = model_bits.pop_front();
			end
		end
		model_prev_ff = (b == MARKER_BYTE);
		return b;
	endfunction

	// bytes are only cut while more bits than one byte are pending
	// so the final byte of a scan waits for the flush that marks it last
	task automatic predict_bytes(input code_word_t w);
		out_byte_t ob;
		for (int i = int'(w.len) - 1; i >= 0; i--) begin
			model_bits.push_back(w.bits[i]);
		end
		while (model_bits.size() > (model_prev_ff ? 7 : 8)) begin
			ob.data = cut_model_byte();
			ob.last = 1'b0;
			exp_q.push_back(ob);
		end
		if (w.flush) begin
			while (model_bits.size() != 0) begin
				ob.data = cut_model_byte();
				ob.last = (model_bits.size() == 0) && (ob.data != MARKER_BYTE);
				exp_q.push_back(ob);
			end
			// a scan may not end on a marker so a zero byte closes it instead
			if (model_prev_ff) begin
				ob.data = 8'h00;
				ob.last = 1'b1;
				exp_q.push_back(ob);
			end
			model_prev_ff = 1'b0;
			scans_sent++;
		end
	endtask

	// one credit is spent per code word, the producer stalls while it holds none
	task automatic send_code(input code_word_t w);
		while (in_cred == 0) begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_code  = w;
		in_cred--;
		predict_bytes(w);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_scans();
		int cycles;
		cycles = 0;
		while (scans_done != scans_sent && cycles < SCAN_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (scans_done != scans_sent) begin
			$display("the last byte of a scan did not arrive within %0d cycles", SCAN_TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_byte(input out_byte_t got, input out_byte_t exp, input int idx);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED {out_data,out_last}[%0d]: got 0x%h expected 0x%h", idx, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED %s: got 0x%h expected 0x%h", what, got, exp);
		end
	endtask

	task automatic compare_scan();
		check_count("out_valid byte count", got_q.size(), exp_q.size());
		for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
			check_byte(got_q[i], exp_q[i], i);
			// a marker must be followed by a stuffed MSB whatever the model says
			if (i > 0 && got_q[i - 1].data == MARKER_BYTE && got_q[i].data[7]) begin
				errors++;
				$display("byte %0d follows a marker byte but its MSB is not zero", i);
			end
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - err_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic pack_aligned_words();
		int err_before;
		err_before = errors;
		credit_gap = 0;
		send_code(make_code(32'h12, 8, 1'b0));
		send_code(make_code(32'h34, 8, 1'b0));
		send_code(make_code(32'h5678, 16, 1'b0));
		send_code(make_code(32'h9abc, 16, 1'b0));
		send_code(make_code(32'hde, 8, 1'b0));
		send_code(make_code(32'h0102, 16, 1'b0));
		send_code(make_code(32'h0, 0, 1'b1));
		wait_scans();
		compare_scan();
		report_test("aligned packing", err_before);
	endtask

	task automatic stuff_marker_bytes();
		int err_before;
		err_before = errors;
		credit_gap = 1;
		send_code(make_code(32'hff, 8, 1'b0));
		send_code(make_code(32'ha5, 8, 1'b0));
		send_code(make_code(32'hffff, 16, 1'b0));
		send_code(make_code(32'h12, 8, 1'b0));
		send_code(make_code(32'h0, 0, 1'b1));
		wait_scans();
		compare_scan();
		report_test("marker stuffing", err_before);
	endtask

	task automatic pad_on_flush();
		int err_before;
		err_before = errors;
		credit_gap = 0;
		// a partial byte is followed by a scan ending on 0xff and by a stuffed padded tail
		send_code(make_code(32'h16, 5, 1'b1));
		send_code(make_code(32'hff, 8, 1'b1));
		send_code(make_code(32'hfff, 12, 1'b1));
		wait_scans();
		compare_scan();
		report_test("flush padding", err_before);
	endtask

	task automatic stall_consumer();
		int err_before;
		err_before = errors;
		credit_gap = 0;
		// let the consumer catch up so the sender starts with all its credits
		while (owed != 0 || gap_cnt != 0) begin
			@(posedge clk);
			#1;
		end
		credit_on = 1'b0;
		fork
			begin
				for (int i = 0; i < T4_WORDS; i++) begin
					send_code(make_code(rand_bits(16), 16, i == T4_WORDS - 1));
				end
			end
			begin
				// only the bytes covered by the reset credits may leave
				// and the full pipeline must stop handing back input credits
				repeat (100) @(posedge clk);
				#1;
				check_count("bytes out under back-pressure", got_q.size(), OUT_CREDITS);
				check_count("in_credit held under back-pressure", in_cred, 0);
				credit_on = 1'b1;
			end
		join
		wait_scans();
		compare_scan();
		report_test("back-pressure", err_before);
	endtask

	task automatic mix_random_lengths();
		int err_before;
		int len;
		err_before = errors;
		credit_gap = 2;
		for (int i = 0; i < T5_WORDS; i++) begin
			len = int'(rand_bits(5)) + 1;
			send_code(make_code(rand_bits(len), len, i == T5_WORDS - 1));
		end
		wait_scans();
		compare_scan();
		report_test("random lengths", err_before);
	endtask

	initial begin
		in_valid      = 1'b0;
		in_code       = '0;
		out_credit    = 1'b0;
		rst_n         = 1'b0;
		lfsr_state    = 32'h0270e91b;
		in_cred       = IN_DEPTH;
		owed          = 0;
		credit_on     = 1'b1;
		credit_gap    = 0;
		gap_cnt       = 0;
		model_prev_ff = 1'b0;
		scans_sent    = 0;
		scans_done    = 0;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		pack_aligned_words();
		stuff_marker_bytes();
		pad_on_flush();
		stall_consumer();
		mix_random_lengths();
		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
hw/jpegls_pack_pkg.sv
hw/credit_fifo.sv
hw/stuffing_packer.sv
hw/byte_sender.sv
hw/jpegls_bit_packer.sv
dv/jpegls_packer_properties.sv
dv/tb_jpegls_bit_packer.sv

// ==== Bender.yml ====
package:
  name: jpegls_bit_packer

sources:
  # RTL in compile order
  - files:
      - hw/jpegls_pack_pkg.sv
      - hw/credit_fifo.sv
      - hw/stuffing_packer.sv
      - hw/byte_sender.sv
      - hw/jpegls_bit_packer.sv

  # testbench and bound assertions
  - target: test
    files:
      - dv/jpegls_packer_properties.sv
      - dv/tb_jpegls_bit_packer.sv
